// ==== logic/rp_sysbus_params.svh ====
// address map and sizing macros for the system bus interconnect, include wherever a width is needed
`ifndef RP_SYSBUS_PARAMS_SVH
`define RP_SYSBUS_PARAMS_SVH

// --------------------------------------------------
// address map
`define RP_SYS_REGIONS       8                      // 1 MB slots on the bus
`define RP_REGIONS_USED      4                      // slots backed by a register bank
`define RP_REGION_LSB        20                     // lowest bit of region index
`define RP_REGION_MSB        29                     // highest bit of region index
`define RP_SYSCONF_REGION    1023                   // top slot holds the static words

// --------------------------------------------------
// configuration words
`define RP_SYSCONF_ID        32'hfff00001           // device class and version
`define RP_SYSCONF_REGIONS   (32'(`RP_SYS_REGIONS)) // value of the region count word
`define RP_SYSCONF_ID_OFS    20'hf0000              // in-slot offset of ID word
`define RP_SYSCONF_NREG_OFS  20'hf0004              // in-slot offset of count word

`define RP_REGION_WORDS      8                      // 32-bit words per register bank

`endif

// ==== logic/rp_sysbus_pkg.sv ====
// shared bus types, import into any block that steers or answers a region request
`include "rp_sysbus_params.svh"

package rp_sysbus_pkg;

  // --------------------------------------------------
  // request on one region slot

  // one strobe per cycle at most
  typedef enum logic [1:0] {
    OP_IDLE  = 2'b00,                           // no access this cycle
    OP_WRITE = 2'b01,                           // byte-enabled write
    OP_READ  = 2'b10                            // full word read
  } bus_op_e;

  // --------------------------------------------------
  // slot numbering

  // wide enough for every slot on the bus, not the config slot
  typedef logic [$clog2(`RP_SYS_REGIONS)-1:0] region_idx_t;

endpackage

// ==== logic/sys_region_if.sv ====
// one region slot of the system bus, decoder drives the request and a register bank answers
`timescale 1ns/1ps

interface sys_region_if;
  import rp_sysbus_pkg::*;

  // --------------------------------------------------
  // request side
  logic [19:0] addr;                            // offset inside the 1 MB slot
  logic [31:0] wdata;                           // write data
  logic [3:0]  sel;                             // byte enables
  bus_op_e     op;                              // idle, write or read

  // --------------------------------------------------
  // response side, one cycle after op
  logic [31:0] rdata;                           // read data
  logic        err;                             // access error
  logic        ack;                             // access done

  // address decoder
  modport req (output addr, wdata, sel, op);

  // slave answering the slot
  modport rsp (input addr, wdata, sel, op, output rdata, err, ack);

  // response collector
  modport mon (input rdata, err, ack);

endinterface

// ==== logic/sys_addr_decode.sv ====
// splits a bus address into slot and offset, steers the strobe and registers who answers next cycle
`timescale 1ns/1ps
`include "rp_sysbus_params.svh"

module sys_addr_decode (
  input  logic                        adc_clk,
  input  logic                        arst_n_i,
  input  logic [31:0]                 addr_i,       // full bus address
  input  logic [31:0]                 wdata_i,
  input  logic [3:0]                  sel_i,
  input  logic                        wen_i,        // write strobe
  input  logic                        ren_i,        // read strobe
  sys_region_if.req                   rgn [`RP_SYS_REGIONS],
  output logic [`RP_SYS_REGIONS-1:0]  resp_cs_o,    // slot answering this cycle
  output logic                        conf_hit_o,   // config slot answering
  output logic [31:0]                 conf_rdata_o  // static word for config read
);
  import rp_sysbus_pkg::*;

  localparam int IDX_W = `RP_REGION_MSB - `RP_REGION_LSB + 1;

  logic [IDX_W-1:0]           rgn_field;            // raw region index
  logic [`RP_REGION_LSB-1:0]  ofs;                  // offset inside slot
  region_idx_t                slot;                 // truncated slot number
  logic                       slot_hit;             // index below slot count
  logic                       conf_sel;             // index is the config slot
  logic                       strobe;               // any access this cycle
  bus_op_e                    op;                   // strobe as an opcode
  logic [`RP_SYS_REGIONS-1:0] cs_nxt;
  logic [31:0]                conf_word;

  // --------------------------------------------------
  // address split
  assign rgn_field = addr_i[`RP_REGION_MSB:`RP_REGION_LSB];
  assign ofs       = addr_i[`RP_REGION_LSB-1:0];
  assign slot      = region_idx_t'(rgn_field);
  assign slot_hit  = rgn_field < IDX_W'(`RP_SYS_REGIONS);
  assign conf_sel  = rgn_field == IDX_W'(`RP_SYSCONF_REGION);
  assign strobe    = wen_i | ren_i;

  always_comb begin
    if (wen_i) op = OP_WRITE;
    else if (ren_i) op = OP_READ;
    else op = OP_IDLE;
  end

  // --------------------------------------------------
  // per-slot steering in the strobe cycle
  for (genvar g = 0; g < `RP_SYS_REGIONS; g++) begin : g_slot
    assign rgn[g].addr  = ofs;                      // every slot sees the offset
    assign rgn[g].wdata = wdata_i;
    assign rgn[g].sel   = sel_i;
    assign rgn[g].op    = (slot_hit && slot == region_idx_t'(g)) ? op : OP_IDLE;
  end

  always_comb begin
    cs_nxt = '0;
    if (strobe && slot_hit) cs_nxt[slot] = 1'b1;    // unmapped index leaves all clear
  end

  // static words by offset
  always_comb begin
    case (ofs)
      `RP_SYSCONF_ID_OFS:   conf_word = `RP_SYSCONF_ID;
      `RP_SYSCONF_NREG_OFS: conf_word = `RP_SYSCONF_REGIONS;
      default:              conf_word = '0;
    endcase
  end

  // --------------------------------------------------
  // response select for cycle n+1
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_cs_o    <= '0;
      conf_hit_o   <= 1'b0;
      conf_rdata_o <= '0;
    end else begin
      resp_cs_o  <= cs_nxt;
      conf_hit_o <= strobe & conf_sel;
      if (strobe && conf_sel) conf_rdata_o <= conf_word; // word of the config access
    end
  end

  // master never raises both strobes
  a_single_strobe: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    !(wen_i && ren_i));

  // at most one responder per cycle including the config slot
  a_one_responder: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    $onehot0({resp_cs_o, conf_hit_o}));

endmodule

// ==== logic/sys_region_regs.sv ====
// small byte-writable register bank answering one bus slot, stands in for an application block
`timescale 1ns/1ps
`include "rp_sysbus_params.svh"

module sys_region_regs (
  input  logic      adc_clk,
  input  logic      arst_n_i,
  sys_region_if.rsp bus                         // request in, response out
);
  import rp_sysbus_pkg::*;

  localparam int WA_W = $clog2(`RP_REGION_WORDS); // word address bits

  logic [31:0]     regs [`RP_REGION_WORDS];     // bank contents
  logic [WA_W-1:0] widx;                        // word index from offset
  logic            in_range;                    // offset inside the bank
  logic            busy;                        // request present this cycle

  // --------------------------------------------------
  // offset decode
  assign widx     = bus.addr[WA_W+1:2];         // byte lanes ignored
  assign in_range = bus.addr[`RP_REGION_LSB-1:WA_W+2] == '0;
  assign busy     = bus.op != OP_IDLE;

  // --------------------------------------------------
  // register write
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int w = 0; w < `RP_REGION_WORDS; w++) begin
        regs[w] <= '0;                          // bank reads zero after reset
      end
    end else if (bus.op == OP_WRITE && in_range) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.sel[b]) begin
          regs[widx][8*b +: 8] <= bus.wdata[8*b +: 8]; // enabled lanes only
        end
      end
    end
  end

  // --------------------------------------------------
  // response, one cycle after op
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bus.ack   <= 1'b0;
      bus.err   <= 1'b0;
      bus.rdata <= '0;
    end else begin
      bus.ack <= busy;                          // every access acks
      bus.err <= busy & ~in_range;              // past last word
      if (bus.op == OP_READ && in_range) begin
        bus.rdata <= regs[widx];
      end else begin
        bus.rdata <= '0;                        // writes and errors return zero
      end
    end
  end

  // the bank never drops or delays an access
  a_ack_next: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    busy |=> bus.ack);

endmodule

// ==== logic/sys_resp_mux.sv ====
// merges region and configuration responses into the single bus response seen by the master
`timescale 1ns/1ps
`include "rp_sysbus_params.svh"

module sys_resp_mux (
  input  logic [`RP_SYS_REGIONS-1:0] resp_cs_i,    // registered slot select
  input  logic                       conf_hit_i,   // registered config select
  input  logic [31:0]                conf_rdata_i, // config word
  sys_region_if.mon                  rgn [`RP_SYS_REGIONS],
  output logic [31:0]                rdata_o,
  output logic                       err_o,
  output logic                       ack_o
);

  logic [31:0]                 used_rdata [`RP_REGIONS_USED]; // bank read data
  logic [`RP_REGIONS_USED-1:0] used_err;
  logic [`RP_REGIONS_USED-1:0] used_ack;

  // --------------------------------------------------
  // gather responses of banked slots
  for (genvar g = 0; g < `RP_REGIONS_USED; g++) begin : g_used
    assign used_rdata[g] = rgn[g].rdata;
    assign used_err[g]   = rgn[g].err;
    assign used_ack[g]   = rgn[g].ack;
  end

  // --------------------------------------------------
  // OR of selected responders
  always_comb begin
    rdata_o = conf_hit_i ? conf_rdata_i : '0;   // config word when its slot hit
    err_o   = 1'b0;                             // config never errors
    ack_o   = conf_hit_i;

    for (int i = 0; i < `RP_REGIONS_USED; i++) begin
      if (resp_cs_i[i]) begin
        rdata_o = rdata_o | used_rdata[i];
        err_o   = err_o | used_err[i];
        ack_o   = ack_o | used_ack[i];
      end
    end

    // empty slots ack with zero data and no error
    for (int i = `RP_REGIONS_USED; i < `RP_SYS_REGIONS; i++) begin
      if (resp_cs_i[i]) ack_o = 1'b1;
    end
  end

  // nothing selected leaves all outputs low

endmodule

// ==== logic/rp_sysbus_top.sv ====
// system bus interconnect top, plain bus ports toward the master and one register bank per used slot
`timescale 1ns/1ps
`include "rp_sysbus_params.svh"

module rp_sysbus_top (
  input  logic        adc_clk,                  // bus clock
  input  logic        arst_n_i,                 // async reset, active low
  input  logic [31:0] sys_addr_i,
  input  logic [31:0] sys_wdata_i,
  input  logic [3:0]  sys_sel_i,                // write byte enables
  input  logic        sys_wen_i,
  input  logic        sys_ren_i,
  output logic [31:0] sys_rdata_o,
  output logic        sys_err_o,
  output logic        sys_ack_o
);

  sys_region_if rgn [`RP_SYS_REGIONS] ();       // one link per slot

  logic [`RP_SYS_REGIONS-1:0] resp_cs;          // decoder to mux
  logic                       conf_hit;
  logic [31:0]                conf_rdata;

  // --------------------------------------------------
  // address decoder
  sys_addr_decode u_addr_decode (
    .adc_clk      (adc_clk),
    .arst_n_i     (arst_n_i),
    .addr_i       (sys_addr_i),
    .wdata_i      (sys_wdata_i),
    .sel_i        (sys_sel_i),
    .wen_i        (sys_wen_i),
    .ren_i        (sys_ren_i),
    .rgn          (rgn),
    .resp_cs_o    (resp_cs),
    .conf_hit_o   (conf_hit),
    .conf_rdata_o (conf_rdata)
  );

  // --------------------------------------------------
  // register banks on the low slots
  for (genvar g = 0; g < `RP_REGIONS_USED; g++) begin : g_bank
    sys_region_regs u_region_regs (
      .adc_clk  (adc_clk),
      .arst_n_i (arst_n_i),
      .bus      (rgn[g])
    );
  end

  // response collector
  sys_resp_mux u_resp_mux (
    .resp_cs_i    (resp_cs),
    .conf_hit_i   (conf_hit),
    .conf_rdata_i (conf_rdata),
    .rgn          (rgn),
    .rdata_o      (sys_rdata_o),
    .err_o        (sys_err_o),
    .ack_o        (sys_ack_o)
  );

endmodule

// ==== tests/sysbus_model.svh ====
// reference model of the bus address map and register banks, include inside the testbench module
`ifndef SYSBUS_MODEL_SVH
`define SYSBUS_MODEL_SVH

// --------------------------------------------------
// register bank copies
logic [31:0] model_regs [`RP_REGIONS_USED][`RP_REGION_WORDS]; // one row per used slot

task automatic model_clear();
  for (int r = 0; r < `RP_REGIONS_USED; r++) begin
    for (int w = 0; w < `RP_REGION_WORDS; w++) begin
      model_regs[r][w] = '0;                    // banks start at zero
    end
  end
endtask

// byte-enabled write of one word
function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                            input logic [3:0] sel);
  logic [31:0] res;
  res = old;
  for (int b = 0; b < 4; b++) begin
    if (sel[b]) res[8*b +: 8] = wdata[8*b +: 8]; // enabled lane takes new byte
  end
  return res;
endfunction

// static words in the top slot
function automatic logic [31:0] conf_word(input logic [19:0] ofs);
  if (ofs == `RP_SYSCONF_ID_OFS) return `RP_SYSCONF_ID;
  if (ofs == `RP_SYSCONF_NREG_OFS) return `RP_SYSCONF_REGIONS;
  return '0;                                    // any other offset reads zero
endfunction

// --------------------------------------------------
// expected {ack, err, rdata} for one bus cycle
task automatic model_access(input logic wen, input logic ren, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] sel,
                            output logic [33:0] exp);
  int          rgn;
  logic [19:0] ofs;
  int          word;
  logic        ack;
  logic        err;
  logic [31:0] data;
  rgn  = 32'(addr[`RP_REGION_MSB:`RP_REGION_LSB]); // slot number
  ofs  = addr[`RP_REGION_LSB-1:0];              // offset inside slot
  word = 32'(ofs >> 2);                         // byte lanes dropped
  ack  = 1'b0;
  err  = 1'b0;
  data = '0;
  if (wen || ren) begin
    if (rgn < `RP_REGIONS_USED) begin
      ack = 1'b1;
      if (word >= `RP_REGION_WORDS) begin
        err = 1'b1;                             // past last word, bank unchanged
      end else if (wen) begin
        model_regs[rgn][word] = merge_bytes(model_regs[rgn][word], wdata, sel);
      end else begin
        data = model_regs[rgn][word];
      end
    end else if (rgn < `RP_SYS_REGIONS) begin
      ack = 1'b1;                               // empty slot, zero data
    end else if (rgn == `RP_SYSCONF_REGION) begin
      ack  = 1'b1;
      data = conf_word(ofs);
    end
    // anything else stays silent
  end
  exp = {ack, err, data};
endtask

`endif

// ==== tests/rp_sysbus_tb.sv ====
// self-checking testbench for the system bus interconnect, drives random strobes and checks each response
`timescale 1ns/1ps
`include "rp_sysbus_params.svh"

module rp_sysbus_tb;

  // --------------------------------------------------
  // access kinds and run length
  localparam int K_BANK   = 0;                  // in-range bank word
  localparam int K_CONF   = 1;                  // config slot read
  localparam int K_UNUSED = 2;                  // slot without a bank
  localparam int K_RANGE  = 3;                  // bank offset past last word
  localparam int K_UNMAP  = 4;                  // no slot at all
  localparam int K_IDLE   = 5;                  // no strobe

  localparam int N_WR   = 64;
  localparam int N_CONF = 8;
  localparam int N_EACH = 16;                   // unused, range and unmapped phases
  localparam int N_MIX  = 200;
  localparam int N_RB   = `RP_REGIONS_USED * `RP_REGION_WORDS; // one full read-back
  localparam int N_TXN  = 4 * N_RB + N_WR + N_CONF + 3 * N_EACH + N_MIX + 16;

  logic        adc_clk;
  logic        arst_n_i;
  logic [31:0] sys_addr_i;
  logic [31:0] sys_wdata_i;
  logic [3:0]  sys_sel_i;
  logic        sys_wen_i;
  logic        sys_ren_i;
  logic [31:0] sys_rdata_o;
  logic        sys_err_o;
  logic        sys_ack_o;

  logic [31:0] lfsr;                            // random state
  logic [33:0] exp_q [$];                       // {ack, err, rdata} per cycle
  int          n_chk;
  int          n_err_ack;
  int          n_err_err;
  int          n_err_data;

  `include "sysbus_model.svh"

  rp_sysbus_top u_rp_sysbus_top (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_sel_i   (sys_sel_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o),
    .sys_ack_o   (sys_ack_o)
  );

  always #10 adc_clk = ~adc_clk;                // 20 ns period

  // --------------------------------------------------
  // random source
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1); // galois, maximal taps
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);                   // one step per bit
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic int mix_kind();
    int k;
    k = rand_bits(3);
    if (k > K_IDLE) k = K_BANK;                 // extra weight on bank traffic
    return k;
  endfunction

  // --------------------------------------------------
  // bus driving
  task automatic drive(input logic wen, input logic ren, input logic [31:0] addr,
                       input logic [31:0] wdata, input logic [3:0] sel);
    @(posedge adc_clk);
    sys_wen_i   <= wen;
    sys_ren_i   <= ren;
    sys_addr_i  <= addr;
    sys_wdata_i <= wdata;
    sys_sel_i   <= sel;
  endtask

  // wr_mode 0 read, 1 write, 2 either
  task automatic do_access(input int kind, input int wr_mode);
    int          r;
    int          pick;
    logic [19:0] ofs;
    logic        wr;
    logic [31:0] d;
    logic [3:0]  s;
    wr   = (wr_mode == 2) ? (rand_bits(1) != 0) : (wr_mode == 1);
    d    = rand_bits(32);
    s    = 4'(rand_bits(4));
    ofs  = 20'(rand_bits(20));
    r    = 0;
    case (kind)
      K_BANK: begin
        r   = rand_bits(2);
        ofs = 20'(rand_bits(3) << 2);           // aligned word inside the bank
      end
      K_CONF: begin
        r    = `RP_SYSCONF_REGION;
        wr   = 1'b0;                            // reads only
        pick = rand_bits(2);
        if (pick == 0) ofs = `RP_SYSCONF_ID_OFS;
        else if (pick == 1) ofs = `RP_SYSCONF_NREG_OFS;
      end
      K_UNUSED: r = `RP_REGIONS_USED + rand_bits(2);
      K_RANGE: begin
        r   = rand_bits(2);
        ofs = ofs | 20'(4 * `RP_REGION_WORDS);  // at least one word past the end
      end
      K_UNMAP: begin
        r = rand_bits(10);
        if (r < `RP_SYS_REGIONS) r = r + `RP_SYS_REGIONS;
        if (r == `RP_SYSCONF_REGION) r = r - 1;
      end
      default: ;
    endcase
    if (kind == K_IDLE) drive(1'b0, 1'b0, '0, '0, '0);
    else drive(wr, !wr, {2'b00, 10'(r), ofs}, d, s);
  endtask

  task automatic read_all();
    for (int r = 0; r < `RP_REGIONS_USED; r++) begin
      for (int w = 0; w < `RP_REGION_WORDS; w++) begin
        drive(1'b0, 1'b1, {2'b00, 10'(r), 20'(4 * w)}, '0, '0);
      end
    end
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("FAILED at %0t: %s is %08h, expected %08h", $time, name, got, exp);
  endtask

  // --------------------------------------------------
  // response check, inputs and outputs both stable at the falling edge
  always @(negedge adc_clk) begin : check_resp
    logic [33:0] e;
    logic [33:0] nxt;
    if (arst_n_i) begin
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();                  // strobe of the previous cycle
        n_chk++;
        if (sys_ack_o !== e[33]) begin
          show_mismatch("sys_ack_o", 32'(sys_ack_o), 32'(e[33]));
          n_err_ack++;
        end
        if (sys_err_o !== e[32]) begin
          show_mismatch("sys_err_o", 32'(sys_err_o), 32'(e[32]));
          n_err_err++;
        end
        if (sys_rdata_o !== e[31:0]) begin
          show_mismatch("sys_rdata_o", sys_rdata_o, e[31:0]);
          n_err_data++;
        end
      end
      model_access(sys_wen_i, sys_ren_i, sys_addr_i, sys_wdata_i, sys_sel_i, nxt);
      exp_q.push_back(nxt);                     // due one cycle later
    end
  end

  initial begin : watchdog
    #(N_TXN * 40 + 2000);
    $display("watchdog expired before the stimulus finished");
    $display("TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // stimulus
  initial begin : stimulus
    arst_n_i    = 1'b0;
    adc_clk     = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_sel_i   = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    lfsr        = 32'd6720;
    n_chk       = 0;
    n_err_ack   = 0;
    n_err_err   = 0;
    n_err_data  = 0;
    model_clear();
    repeat (10) @(posedge adc_clk);
    arst_n_i <= 1'b1;

    read_all();                                 // all zero after reset
    repeat (N_WR) do_access(K_BANK, 1);
    read_all();
    repeat (N_CONF) do_access(K_CONF, 0);
    repeat (N_EACH) do_access(K_UNUSED, 2);
    repeat (N_EACH) do_access(K_RANGE, 2);
    repeat (N_EACH) do_access(K_UNMAP, 2);
    read_all();                                 // banks untouched by the phases above
    for (int i = 0; i < N_MIX; i++) begin
      do_access(mix_kind(), 2);                 // back to back, every kind
    end
    read_all();
    do_access(K_IDLE, 0);
    repeat (3) @(posedge adc_clk);              // drain the last response

    $display("checks %0d, errors ack %0d err %0d rdata %0d", n_chk, n_err_ack, n_err_err,
             n_err_data);
    if (n_err_ack + n_err_err + n_err_data == 0 && n_chk > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+logic
+incdir+tests
logic/rp_sysbus_pkg.sv
logic/sys_region_if.sv
logic/sys_addr_decode.sv
logic/sys_region_regs.sv
logic/sys_resp_mux.sv
logic/rp_sysbus_top.sv
tests/rp_sysbus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the system bus testbench with Verilator.
# Exits non-zero unless the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module rp_sysbus_tb -o sim_rp_sysbus
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_rp_sysbus)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
